/* flist.f */
logic/msx_dev_pkg.sv
logic/psg_tone.sv
logic/scc_sound.sv
logic/msx2_ram_mapper.sv
logic/zemina_mapper.sv
logic/devices.sv
sim/tb_devices.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_devices -f flist.f -o tb_devices

./obj_dir/tb_devices > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation clean"

/* sim/tb_devices.sv */
module tb_devices import msx_dev_pkg::*; ();

    logic                      clk;
    logic                      rst_n;
    logic               [15:0] addr;
    logic                [7:0] wdata;
    logic                      req;
    logic                      wr;
    logic                      iorq;
    logic                      mreq;
    logic      [DEV_COUNT-1:0] dev_en;
    logic signed [SOUND_W-1:0] sound;
    logic                [7:0] data;
    logic                      output_rq;
    logic                [7:0] data_to_mapper;

    // Reference model state
    logic                [7:0] page_m [4];
    logic                [7:0] bank_m;
    logic                [7:0] wave_m [SCC_CHANNELS*WAVE_LEN];
    logic                [3:0] psg_idx_m;
    logic                [3:0] psg_vol_m;
    logic                [7:0] exp_data;          // Read bus one cycle after request
    logic                      exp_rq;
    logic                [7:0] exp_map;
    logic signed [SOUND_W-1:0] exp_lvl;           // PSG magnitude, sound is +/- this
    logic                      map_port;
    logic                      wave_hit;
    logic                      in_window;
    logic                      rd_req;

    int     err_cnt;
    int     pos_cnt;
    int     neg_cnt;
    integer seed;

    devices u_devices (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .req(req), .wr(wr), .iorq(iorq), .mreq(mreq), .dev_en(dev_en),
        .sound(sound), .data(data), .output_rq(output_rq),
        .data_to_mapper(data_to_mapper)
    );

    always #2 clk = ~clk;

    assign map_port  = addr[7:0] >= MAP_PORT_BASE;                 // FC..FF
    assign wave_hit  = (addr >= SCC_BASE) && (addr <= SCC_WAVE_END);
    assign in_window = (addr >= 16'h4000) && (addr <= 16'hBFFF);
    assign rd_req    = req && !wr && ((iorq && dev_en[RAM_MAP] && map_port)
                       || (mreq && dev_en[SCC] && wave_hit));

    // Expected mapper page, idle sources give FF
    always_comb begin
        exp_map = IDLE_DATA;
        if (mreq && dev_en[RAM_MAP]) begin
            exp_map = page_m[addr[15:14]];
        end
        if (mreq && dev_en[ZEMINA] && in_window) begin
            exp_map = exp_map & bank_m;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                page_m[i] <= '0;
            end
            bank_m    <= '0;
            psg_idx_m <= '0;
            psg_vol_m <= '0;
            exp_data  <= IDLE_DATA;
            exp_rq    <= 1'b0;
            exp_lvl   <= '0;
        end else begin
            exp_data <= IDLE_DATA;
            exp_rq   <= rd_req;
            exp_lvl  <= SOUND_W'(psg_vol_m * 256);    // Sound register lags volume by one
            if (req && iorq && dev_en[RAM_MAP] && map_port) begin
                if (wr) begin
                    page_m[addr[1:0]] <= wdata;
                end else begin
                    exp_data <= page_m[addr[1:0]];
                end
            end
            if (req && mreq && !wr && dev_en[SCC] && wave_hit) begin
                exp_data <= wave_m[addr[6:0]];
            end
            if (req && wr && iorq && dev_en[ZEMINA] && addr[7:0] == ZEMINA_PORT) begin
                bank_m <= wdata;
            end
            if (req && wr && iorq && dev_en[PSG]) begin
                if (addr[7:0] == PSG_ADDR_PORT) begin
                    psg_idx_m <= wdata[3:0];
                end else if (addr[7:0] == PSG_DATA_PORT && psg_idx_m == 4'd8) begin
                    psg_vol_m <= wdata[3:0];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (req && mreq && wr && dev_en[SCC] && wave_hit) begin
            wave_m[addr[6:0]] <= wdata;
        end
    end

    // Both polarities must show up while the tone runs
    always @(negedge clk) begin
        if (rst_n && exp_lvl != 0) begin
            if (sound > 0) begin
                pos_cnt++;
            end else if (sound < 0) begin
                neg_cnt++;
            end
        end
    end

    a_reset_idle: assert property (@(negedge clk)
        $rose(rst_n) |-> (!output_rq && data == 8'hFF && data_to_mapper == 8'hFF && sound == 0))
        else begin
            err_cnt++;
            $display("FAIL reset state output_rq %h data %h data_to_mapper %h sound %h",
                     output_rq, data, data_to_mapper, sound);
        end

    a_data: assert property (@(negedge clk) disable iff (!rst_n) data == exp_data)
        else begin
            err_cnt++;
            $display("FAIL data expected %h got %h", exp_data, data);
        end

    a_output_rq: assert property (@(negedge clk) disable iff (!rst_n) output_rq == exp_rq)
        else begin
            err_cnt++;
            $display("FAIL output_rq expected %h got %h", exp_rq, output_rq);
        end

    a_rq_cause: assert property (@(negedge clk) disable iff (!rst_n) output_rq |-> $past(rd_req))
        else begin
            err_cnt++;
            $display("ERROR: output_rq pulsed without a read request in the cycle before");
        end

    a_mapper: assert property (@(negedge clk) disable iff (!rst_n) data_to_mapper == exp_map)
        else begin
            err_cnt++;
            $display("FAIL data_to_mapper expected %h got %h", exp_map, data_to_mapper);
        end

    a_sound: assert property (@(negedge clk) disable iff (!rst_n)
        (sound == exp_lvl) || (sound == -exp_lvl))
        else begin
            err_cnt++;
            $display("FAIL sound expected +/-%h got %h", exp_lvl, sound);
        end

    function automatic logic [7:0] rand_byte();
        rand_byte = 8'($random(seed));
    endfunction

    function automatic logic [15:0] rand_wave_addr();
        rand_wave_addr = SCC_BASE | 16'($random(seed) & 32'h7F);
    endfunction

    // One request cycle, then the strobes drop for a cycle
    task automatic bus_op(input logic [15:0] a, input logic [7:0] d, input logic w,
                          input logic io);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= w;
        iorq  <= io;
        mreq  <= !io;
        req   <= 1'b1;
        @(posedge clk);
        req   <= 1'b0;
        wr    <= 1'b0;
        iorq  <= 1'b0;
        mreq  <= 1'b0;
    endtask

    task automatic io_op(input logic [7:0] port, input logic [7:0] d, input logic w);
        bus_op({rand_byte(), port}, d, w, 1'b1);   // Upper address byte is don't care
    endtask

    task automatic psg_write(input logic [3:0] idx, input logic [7:0] d);
        io_op(PSG_ADDR_PORT, {4'h0, idx}, 1'b1);
        io_op(PSG_DATA_PORT, d, 1'b1);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    initial begin
        logic [15:0] a;
        logic  [7:0] p;
        int          v;
        seed    = 32'h979a;
        clk     = 1'b0;
        rst_n   = 1'b0;
        addr    = '0;
        wdata   = '0;
        req     = 1'b0;
        wr      = 1'b0;
        iorq    = 1'b0;
        mreq    = 1'b0;
        dev_en  = '1;
        err_cnt = 0;
        pos_cnt = 0;
        neg_cnt = 0;
        idle(16);
        rst_n <= 1'b1;
        idle(4);

        // SCC wave table, fully written so any later read is defined
        for (int i = 0; i < SCC_CHANNELS*WAVE_LEN; i++) begin
            bus_op(SCC_BASE + 16'(i), rand_byte(), 1'b1, 1'b0);
        end
        repeat (40) begin
            a = rand_wave_addr();
            bus_op(a, rand_byte(), 1'b1, 1'b0);
            bus_op(a, 8'h00, 1'b0, 1'b0);
        end
        dev_en[SCC] <= 1'b0;
        repeat (10) bus_op(rand_wave_addr(), 8'h00, 1'b0, 1'b0);
        dev_en[SCC] <= 1'b1;

        // PSG tone, SCC channels stay disabled
        v = 1 + ({$random(seed)} % 15);
        psg_write(PSG_REG_FINE, 8'd20);
        psg_write(PSG_REG_COARSE, 8'd0);
        psg_write(PSG_REG_VOL, 8'(v));
        idle(200);
        psg_write(PSG_REG_VOL, 8'd0);
        idle(50);
        if (pos_cnt == 0 || neg_cnt == 0) begin
            err_cnt++;
            $display("ERROR: PSG tone never swung to both polarities");
        end

        // RAM mapper alone
        dev_en[ZEMINA] <= 1'b0;
        repeat (32) begin
            p = MAP_PORT_BASE | 8'($random(seed) & 3);
            io_op(p, rand_byte(), 1'b1);
            io_op(p, 8'h00, 1'b0);
        end
        repeat (64) bus_op(16'($random(seed)), 8'h00, 1'b0, 1'b0);

        // Zemina bank, first combined with the RAM mapper, then alone
        dev_en[ZEMINA] <= 1'b1;
        io_op(ZEMINA_PORT, rand_byte(), 1'b1);
        repeat (64) bus_op(16'($random(seed)), 8'h00, 1'b0, 1'b0);
        dev_en[RAM_MAP] <= 1'b0;
        repeat (32) bus_op(16'($random(seed)), 8'h00, 1'b0, 1'b0);
        dev_en[RAM_MAP] <= 1'b1;
        idle(4);

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Twice the stimulus length of 1176 cycles
    initial begin
        #(1176 * 4 * 2);
        $display("ERROR: watchdog expired before the stimulus finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* logic/devices.sv */
module devices import msx_dev_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic               [15:0] addr,
    input  logic                [7:0] wdata,
    input  logic                      req,
    input  logic                      wr,
    input  logic                      iorq,
    input  logic                      mreq,
    input  logic      [DEV_COUNT-1:0] dev_en,
    output logic signed [SOUND_W-1:0] sound,            // Mixed audio
    output logic                [7:0] data,             // Read bus, idle is FF
    output logic                      output_rq,        // Some device answers
    output logic                [7:0] data_to_mapper    // Segment for memory slot
);

    logic signed [SOUND_W-1:0] psg_level;
    logic signed [SOUND_W-1:0] scc_level;
    logic                [7:0] scc_data;
    logic                      scc_output_rq;
    logic                [7:0] msx2_ram_data;
    logic                      msx2_ram_output_rq;
    logic                [7:0] msx2_ram_data_to_mapper;
    logic                [7:0] zemina_data_to_mapper;

    // Idle devices drive FF so AND merges readers
    assign sound          = psg_level + scc_level;
    assign data           = scc_data & msx2_ram_data;
    assign output_rq      = scc_output_rq | msx2_ram_output_rq;
    assign data_to_mapper = msx2_ram_data_to_mapper & zemina_data_to_mapper;

    psg_tone psg (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .req(req), .wr(wr), .iorq(iorq), .dev_en(dev_en),
        .sound(psg_level)
    );

    scc_sound scc (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .req(req), .wr(wr), .mreq(mreq), .dev_en(dev_en),
        .sound(scc_level),
        .data(scc_data),
        .output_rq(scc_output_rq)
    );

    msx2_ram_mapper msx2_ram (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .req(req), .wr(wr), .iorq(iorq), .mreq(mreq), .dev_en(dev_en),
        .data(msx2_ram_data),
        .output_rq(msx2_ram_output_rq),
        .data_to_mapper(msx2_ram_data_to_mapper)
    );

    zemina_mapper zemina (
        .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata),
        .req(req), .wr(wr), .iorq(iorq), .mreq(mreq), .dev_en(dev_en),
        .data_to_mapper(zemina_data_to_mapper)
    );

endmodule

/* logic/zemina_mapper.sv */
module zemina_mapper import msx_dev_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic          [15:0] addr,
    input  logic           [7:0] wdata,
    input  logic                 req,
    input  logic                 wr,
    input  logic                 iorq,
    input  logic                 mreq,
    input  logic [DEV_COUNT-1:0] dev_en,
    output logic           [7:0] data_to_mapper
);

    logic [7:0] bank;
    logic       bank_wr;
    logic       in_window;

    assign bank_wr   = req && wr && iorq && dev_en[ZEMINA] && (addr[7:0] == ZEMINA_PORT);
    assign in_window = (addr >= ZEMINA_WIN_LO) && (addr <= ZEMINA_WIN_HI);

    // Write-only, no readback path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank <= '0;
        end else if (bank_wr) begin
            bank <= wdata;
        end
    end

    always_comb begin
        if (mreq && dev_en[ZEMINA] && in_window) begin
            data_to_mapper = bank;      // Pages 1 and 2 only
        end else begin
            data_to_mapper = IDLE_DATA;
        end
    end

endmodule

/* logic/msx2_ram_mapper.sv */
module msx2_ram_mapper import msx_dev_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic          [15:0] addr,
    input  logic           [7:0] wdata,
    input  logic                 req,
    input  logic                 wr,
    input  logic                 iorq,
    input  logic                 mreq,
    input  logic [DEV_COUNT-1:0] dev_en,
    output logic           [7:0] data,
    output logic                 output_rq,
    output logic           [7:0] data_to_mapper
);

    logic [7:0] page [4];               // One segment per 16K page
    logic       port_hit;
    logic       io_wr;
    logic       io_rd;

    assign port_hit = iorq && dev_en[RAM_MAP] && (addr[7:2] == MAP_PORT_BASE[7:2]);
    assign io_wr    = req && wr && port_hit;
    assign io_rd    = req && !wr && port_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                page[i] <= '0;
            end
        end else if (io_wr) begin
            page[addr[1:0]] <= wdata;   // FC is page 0
        end
    end

    // Port readback, one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data      <= IDLE_DATA;
            output_rq <= 1'b0;
        end else begin
            data      <= io_rd ? page[addr[1:0]] : IDLE_DATA;
            output_rq <= io_rd;
        end
    end

    // Segment lookup for the memory slot
    always_comb begin
        if (mreq && dev_en[RAM_MAP]) begin
            data_to_mapper = page[addr[15:14]];
        end else begin
            data_to_mapper = IDLE_DATA;
        end
    end

    a_map_idle_no_mreq: assert property (
        @(posedge clk) disable iff (!rst_n)
        !mreq |-> (data_to_mapper == IDLE_DATA)
    );

endmodule

/* logic/scc_sound.sv */
module scc_sound import msx_dev_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic               [15:0] addr,
    input  logic                [7:0] wdata,
    input  logic                      req,
    input  logic                      wr,
    input  logic                      mreq,
    input  logic      [DEV_COUNT-1:0] dev_en,
    output logic signed [SOUND_W-1:0] sound,
    output logic                [7:0] data,
    output logic                      output_rq
);

    localparam int PROD_W = 13;             // 8-bit sample times 5-bit signed volume

    scc_region_t region;
    logic        mem_acc;
    logic        mem_wr;
    logic        rd_wave;
    logic [CH_W-1:0] vol_ch;

    logic [7:0]  wave_ram [SCC_CHANNELS*WAVE_LEN];
    logic [11:0] freq     [SCC_CHANNELS];
    logic [3:0]  vol      [SCC_CHANNELS];
    logic [SCC_CHANNELS-1:0] ch_en;

    logic [11:0]           div_cnt  [SCC_CHANNELS];
    logic [WAVE_IDX_W-1:0] wave_idx [SCC_CHANNELS];

    logic [CH_W-1:0]            mix_ch;
    logic signed [7:0]          sample;
    logic signed [PROD_W-1:0]   prod;
    logic signed [SOUND_W-1:0]  term;
    logic signed [SOUND_W-1:0]  acc;

    // Address window decode
    always_comb begin
        region = NONE;
        if (addr >= SCC_BASE && addr <= SCC_WAVE_END) begin
            region = WAVE;
        end else if (addr > SCC_WAVE_END && addr <= SCC_REG_END) begin
            case (addr[3:0]) inside
                [4'h0:4'h7]: region = FREQ;
                [4'hA:4'hD]: region = VOL;
                4'hF:        region = CH_EN;
                default:     region = NONE;     // 9888, 9889, 988E unused
            endcase
        end
    end

    assign mem_acc = req && mreq && dev_en[SCC];
    assign mem_wr  = mem_acc && wr;
    assign rd_wave = mem_acc && !wr && (region == WAVE);
    assign vol_ch  = addr[1:0] + 2'd2;      // 988A is channel 0

    always_ff @(posedge clk) begin
        if (mem_wr && region == WAVE) begin
            wave_ram[addr[6:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SCC_CHANNELS; i++) begin
                freq[i] <= '0;
                vol[i]  <= '0;
            end
            ch_en <= '0;
        end else if (mem_wr) begin
            case (region)
                FREQ: begin
                    if (addr[0]) freq[addr[2:1]][11:8] <= wdata[3:0];
                    else         freq[addr[2:1]][7:0]  <= wdata;
                end
                VOL:     vol[vol_ch] <= wdata[3:0];
                CH_EN:   ch_en       <= wdata[SCC_CHANNELS-1:0];
                default: ;
            endcase
        end
    end

    // Only the wave table reads back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data      <= IDLE_DATA;
            output_rq <= 1'b0;
        end else begin
            data      <= rd_wave ? wave_ram[addr[6:0]] : IDLE_DATA;
            output_rq <= rd_wave;
        end
    end

    // Per-channel frequency dividers step the wave pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SCC_CHANNELS; i++) begin
                div_cnt[i]  <= '0;
                wave_idx[i] <= '0;
            end
        end else begin
            for (int i = 0; i < SCC_CHANNELS; i++) begin
                if (div_cnt[i] >= freq[i]) begin
                    div_cnt[i]  <= '0;
                    wave_idx[i] <= wave_idx[i] + 1'b1;
                end else begin
                    div_cnt[i] <= div_cnt[i] + 1'b1;
                end
            end
        end
    end

    // One channel per cycle through a shared multiplier
    always_comb begin
        sample = wave_ram[{mix_ch, wave_idx[mix_ch]}];
        prod   = sample * $signed({1'b0, vol[mix_ch]});
        term   = ch_en[mix_ch] ? {{(SOUND_W-PROD_W){prod[PROD_W-1]}}, prod} : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_ch <= '0;
            acc    <= '0;
            sound  <= '0;
        end else begin
            mix_ch <= mix_ch + 1'b1;
            if (mix_ch == CH_W'(SCC_CHANNELS-1)) begin
                sound <= acc + term;            // Full round done
                acc   <= '0;
            end else begin
                acc <= acc + term;
            end
        end
    end

    // Wave window 9800..987F has fixed address bits 15..7
    a_scc_rq_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        output_rq |-> $past(req && mreq && !wr && dev_en[SCC]
                            && addr[15:7] == SCC_BASE[15:7])
    );

endmodule

/* logic/psg_tone.sv */
module psg_tone import msx_dev_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic               [15:0] addr,
    input  logic                [7:0] wdata,
    input  logic                      req,
    input  logic                      wr,
    input  logic                      iorq,
    input  logic      [DEV_COUNT-1:0] dev_en,
    output logic signed [SOUND_W-1:0] sound
);

    logic                    io_wr;
    logic              [3:0] reg_idx;       // Latched register number
    logic [PSG_PERIOD_W-1:0] period;
    logic              [3:0] volume;
    logic [PSG_PERIOD_W-1:0] period_cnt;
    logic                    phase;         // Square wave polarity
    logic signed [SOUND_W-1:0] level;

    assign io_wr = req && wr && iorq && dev_en[PSG];

    // Register file access through the address/data port pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_idx <= '0;
            period  <= '0;
            volume  <= '0;
        end else if (io_wr) begin
            if (addr[7:0] == PSG_ADDR_PORT) begin
                reg_idx <= wdata[3:0];
            end else if (addr[7:0] == PSG_DATA_PORT) begin
                case (reg_idx)
                    PSG_REG_FINE:   period[7:0]  <= wdata;
                    PSG_REG_COARSE: period[11:8] <= wdata[3:0];
                    PSG_REG_VOL:    volume       <= wdata[3:0];
                    default: ;                  // Other registers not implemented
                endcase
            end
        end
    end

    // Tone divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt <= '0;
            phase      <= 1'b0;
        end else if (period_cnt >= period) begin
            period_cnt <= '0;
            phase      <= ~phase;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // Volume scaled to the upper byte, zero volume gives silence
    assign level = {4'b0000, volume, 8'h00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sound <= '0;
        end else begin
            sound <= phase ? level : -level;
        end
    end

    // Top-level sum relies on this bound to avoid overflow
    a_psg_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sound <= PSG_MAX_LEVEL) && (sound >= -PSG_MAX_LEVEL)
    );

endmodule

/* logic/msx_dev_pkg.sv */
package msx_dev_pkg;

    // Device identity, indexes the dev_en vector
    typedef enum logic [1:0] {
        PSG,
        SCC,
        RAM_MAP,
        ZEMINA
    } dev_id_t;

    localparam int DEV_COUNT = 4;

    // Fixed I/O port map
    localparam logic [7:0] PSG_ADDR_PORT = 8'hA0;
    localparam logic [7:0] PSG_DATA_PORT = 8'hA1;
    localparam logic [7:0] MAP_PORT_BASE = 8'hFC;       // FC..FF, one port per page
    localparam logic [7:0] ZEMINA_PORT   = 8'h77;

    // PSG register numbers and limits
    localparam logic [3:0] PSG_REG_FINE   = 4'd0;       // Period low byte
    localparam logic [3:0] PSG_REG_COARSE = 4'd1;       // Period high nibble
    localparam logic [3:0] PSG_REG_VOL    = 4'd8;
    localparam int         PSG_PERIOD_W   = 12;
    localparam int         PSG_MAX_LEVEL  = 3840;       // 15 * 256

    // SCC memory window
    localparam logic [15:0] SCC_BASE     = 16'h9800;
    localparam logic [15:0] SCC_WAVE_END = 16'h987F;
    localparam logic [15:0] SCC_REG_END  = 16'h988F;

    typedef enum logic [2:0] {
        WAVE,
        FREQ,
        VOL,
        CH_EN,
        NONE
    } scc_region_t;

    localparam int SCC_CHANNELS = 4;
    localparam int WAVE_LEN     = 32;
    localparam int CH_W         = $clog2(SCC_CHANNELS);
    localparam int WAVE_IDX_W   = $clog2(WAVE_LEN);

    // Zemina bank window
    localparam logic [15:0] ZEMINA_WIN_LO = 16'h4000;
    localparam logic [15:0] ZEMINA_WIN_HI = 16'hBFFF;

    localparam logic [7:0] IDLE_DATA = 8'hFF;           // Idle bus value, ANDed at top
    localparam int         SOUND_W   = 16;

endpackage
